//--- dv/radio_core_tb.sv
`timescale 1ns/1ns
/*
 * Radio core testbench: LED select, time load and readback, PPS capture,
 * decimation against a reference model, merging and overrun
 */
module radio_core_tb;

   localparam int FEED_LEN    = 160;
   localparam int PPS_GAP     = 37;
   localparam int DRAIN_LIMIT = 64;
   // Four sample runs plus setup, PPS and drain time, with twice the margin
   localparam int WATCHDOG_NS = 2 * 10 * (4 * FEED_LEN + 4 * DRAIN_LIMIT + 300);
   localparam logic [63:0] TIME_LOAD = 64'h0123_4567_ffff_fffd;

   logic                dsp_clk = 1'b0;
   logic                por_rst;
   radio_pkg::set_bus_t set_bus;
   radio_pkg::iq_in_t   adc;
   logic                adc_stb;
   logic                pps;
   radio_pkg::rb_sel_e  rb_sel;
   logic [31:0]         rb_data;
   logic [7:0]          leds;
   radio_pkg::iq_acc_t  out_sample;
   logic                out_chan;
   logic                out_stb;

   // Reference model state with one entry per channel
   logic [15:0]         lfsr = 16'd56;
   bit                  run_m [2];
   int                  rate_m [2];
   int                  cnt_m [2];
   logic signed [23:0]  acc_i [2];
   logic signed [23:0]  acc_q [2];
   bit                  lossy1 = 1'b0;
   radio_pkg::iq_acc_t  exp0 [$];
   radio_pkg::iq_acc_t  exp1 [$];
   radio_pkg::iq_acc_t  exp_s;
   logic [31:0]         p1;
   logic [31:0]         p2;

   radio_core #(.NUM_CHAN(2)) UUT (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_i(set_bus), .adc_i(adc), .adc_stb_i(adc_stb), .pps_i(pps),
      .rb_sel_i(rb_sel), .rb_data_o(rb_data), .leds_o(leds),
      .out_sample_o(out_sample), .out_chan_o(out_chan), .out_stb_o(out_stb)
   );

   always #5 dsp_clk = ~dsp_clk;

   //////////////////////////////
   // Failure reporting
   task automatic halt_fail();
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic fail_reason(input string why);
      $display("%s", why);
      halt_fail();
   endtask

   task automatic check_val(input string sig, input logic [63:0] got, input logic [63:0] exp);
      assert (got == exp) else begin
         $display("ERR time=%0t %s got=%h expected=%h", $time, sig, got, exp);
         halt_fail();
      end
   endtask

   //////////////////////////////
   // Stimulus helpers
   // x^16 + x^14 + x^13 + x^11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic rand_word(input int nbits, output logic [31:0] v);
      v = '0;
      for (int b = 0; b < nbits; b++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic step();
      @(posedge dsp_clk);
      #1;
   endtask

   task automatic write_set(input logic [7:0] addr, input logic [31:0] data);
      set_bus.stb  = 1'b1;
      set_bus.addr = addr;
      set_bus.data = data;
      step();
      set_bus.stb = 1'b0;
   endtask

   // Channel windows start at 32 with a stride of 16
   task automatic set_chan(input int c, input bit run, input int rate);
      logic [7:0] base;
      base = 8'(32 + 16 * c);
      write_set(base + 8'd1, 32'(rate));
      write_set(base, {31'd0, run});
      run_m[c]  = run;
      rate_m[c] = rate;
      cnt_m[c]  = 0;
      acc_i[c]  = '0;
      acc_q[c]  = '0;
      step();
      step();
   endtask

   // Each LED takes the hardware bit where its source bit is set
   function automatic logic [7:0] led_model(input logic [7:0] sw, input logic [7:0] src,
                                            input logic [1:0] run);
      logic [7:0] hw;
      logic [7:0] leds_exp;
      hw = {6'd0, run};
      for (int b = 0; b < 8; b++) begin
         if (src[b]) begin
            leds_exp[b] = hw[b];
         end else begin
            leds_exp[b] = sw[b];
         end
      end
      return leds_exp;
   endfunction

   // Drive n cycles of ADC data and sum each channel's groups
   task automatic feed(input int n, input bit dense);
      logic [31:0]        w;
      logic [31:0]        s;
      logic signed [23:0] xi;
      logic signed [23:0] xq;
      radio_pkg::iq_acc_t e;
      for (int k = 0; k < n; k++) begin
         rand_word(32, w);
         if (dense) s = 32'd1;
         else rand_word(1, s);
         adc.i   = w[31:16];
         adc.q   = w[15:0];
         adc_stb = s[0];
         xi = {{8{w[31]}}, w[31:16]};
         xq = {{8{w[15]}}, w[15:0]};
         for (int c = 0; c < 2; c++) begin
            if (s[0] && run_m[c]) begin
               acc_i[c] = acc_i[c] + xi;
               acc_q[c] = acc_q[c] + xq;
               cnt_m[c]++;
               if (cnt_m[c] == rate_m[c]) begin
                  e.i = acc_i[c];
                  e.q = acc_q[c];
                  if (c == 0) begin
                     exp0.push_back(e);
                  end else begin
                     // Channel 1 starved behind channel 0 keeps only its newest sample
                     if (lossy1) exp1.delete();
                     exp1.push_back(e);
                  end
                  cnt_m[c] = 0;
                  acc_i[c] = '0;
                  acc_q[c] = '0;
               end
            end
         end
         step();
      end
      adc_stb = 1'b0;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while ((exp0.size() != 0 || exp1.size() != 0) && waited < DRAIN_LIMIT) begin
         step();
         waited++;
      end
      if (exp0.size() != 0 || exp1.size() != 0) begin
         fail_reason("expected samples never came out of the merger");
      end else begin
         repeat (4) step();
      end
   endtask

   //////////////////////////////
   // Output monitor sampled mid-cycle
   always @(negedge dsp_clk) begin
      if (!por_rst && out_stb) begin
         if (out_chan == 1'b0 && exp0.size() != 0) begin
            exp_s = exp0.pop_front();
            check_val("out_sample_o", 64'(out_sample), 64'(exp_s));
         end else if (out_chan == 1'b1 && exp1.size() != 0) begin
            exp_s = exp1.pop_front();
            check_val("out_sample_o", 64'(out_sample), 64'(exp_s));
         end else begin
            fail_reason($sformatf("channel %0d sent a sample that was not expected", out_chan));
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      fail_reason("watchdog expired before the tests finished");
   end

   //////////////////////////////
   // Test sequence
   initial begin
      por_rst = 1'b1;
      set_bus = '0;
      adc     = '0;
      adc_stb = 1'b0;
      pps     = 1'b0;
      rb_sel  = radio_pkg::RB_COMPAT;
      repeat (4) @(posedge dsp_clk);
      #1;
      por_rst = 1'b0;
      step();

      // LEDs
      check_val("leds_o", 64'(leds), 64'(led_model(8'h00, 8'h03, 2'b00)));
      set_chan(0, 1'b1, 1);
      check_val("leds_o", 64'(leds), 64'(led_model(8'h00, 8'h03, 2'b01)));
      write_set(8'd0, 32'h5a);
      step();
      check_val("leds_o", 64'(leds), 64'(led_model(8'h5a, 8'h03, 2'b01)));
      write_set(8'd1, 32'h0f);
      step();
      check_val("leds_o", 64'(leds), 64'(led_model(8'h5a, 8'h0f, 2'b01)));
      set_chan(0, 1'b0, 1);
      check_val("leds_o", 64'(leds), 64'(led_model(8'h5a, 8'h0f, 2'b00)));

      // Compat word holds major 3 and minor 1
      step();
      check_val("rb_data_o compat", 64'(rb_data), 64'h0003_0001);

      // Time load across a carry in the low word
      rb_sel = radio_pkg::RB_TIME_LO;
      write_set(8'd10, TIME_LOAD[63:32]);
      write_set(8'd11, TIME_LOAD[31:0]);
      step();
      step();
      for (int n = 0; n < 4; n++) begin
         check_val("rb_data_o time lo", 64'(rb_data), 64'((TIME_LOAD + 64'(n)) & 64'hffff_ffff));
         step();
      end
      rb_sel = radio_pkg::RB_TIME_HI;
      step();
      check_val("rb_data_o time hi", 64'(rb_data), (TIME_LOAD + 64'd5) >> 32);

      // PPS
      rb_sel = radio_pkg::RB_PPS_LO;
      pps = 1'b1;
      repeat (3) step();
      pps = 1'b0;
      repeat (8) step();
      p1 = rb_data;
      repeat (PPS_GAP - 11) step();
      pps = 1'b1;
      repeat (3) step();
      pps = 1'b0;
      repeat (8) step();
      p2 = rb_data;
      check_val("rb_data_o pps delta", 64'(p2 - p1), 64'(PPS_GAP));

      // Decimation with one channel at a time
      set_chan(0, 1'b1, 4);
      feed(FEED_LEN, 1'b0);
      wait_drain();
      set_chan(0, 1'b0, 4);
      set_chan(1, 1'b1, 3);
      feed(FEED_LEN, 1'b0);
      wait_drain();
      set_chan(1, 1'b0, 3);

      // Both channels at rate 5 share the output without loss
      rb_sel = radio_pkg::RB_STATUS;
      set_chan(0, 1'b1, 5);
      set_chan(1, 1'b1, 5);
      feed(FEED_LEN, 1'b1);
      wait_drain();
      check_val("rb_data_o status", 64'(rb_data), 64'h0000_0003);
      set_chan(0, 1'b0, 5);
      set_chan(1, 1'b0, 5);

      // Rate 1 on both overruns channel 1 only
      set_chan(0, 1'b1, 1);
      set_chan(1, 1'b1, 1);
      lossy1 = 1'b1;
      feed(FEED_LEN, 1'b1);
      wait_drain();
      check_val("rb_data_o status", 64'(rb_data), 64'h0000_0203);

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

//--- rtl/radio_core.sv
`timescale 1ns/1ns
/*
 * Radio core top: settings hub, timekeeper, receive channels
 * and the stream merger on one DSP clock
 */
module radio_core #(
   parameter int NUM_CHAN = 2
) (
   input  logic                  dsp_clk,
   input  logic                  por_rst,
   input  radio_pkg::set_bus_t   set_i,
   input  radio_pkg::iq_in_t     adc_i,
   input  logic                  adc_stb_i,
   input  logic                  pps_i,
   input  radio_pkg::rb_sel_e    rb_sel_i,
   output logic [31:0]           rb_data_o,
   output logic [7:0]            leds_o,
   output radio_pkg::iq_acc_t    out_sample_o,
   output logic [((NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1)-1:0] out_chan_o,
   output logic                  out_stb_o
);

   radio_pkg::set_bus_t   set_bus;
   radio_pkg::vita_time_t vita_time;
   radio_pkg::vita_time_t vita_pps;
   radio_pkg::iq_acc_t    rx_sample [NUM_CHAN];
   logic [NUM_CHAN-1:0]   rx_stb;
   logic [NUM_CHAN-1:0]   rx_run;
   logic [NUM_CHAN-1:0]   overrun;

   //////////////////////////////
   // Settings and readback
   settings_hub #(.NUM_CHAN(NUM_CHAN)) u_hub (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_i(set_i), .set_o(set_bus),
      .run_i(rx_run), .overrun_i(overrun),
      .vita_time_i(vita_time), .vita_pps_i(vita_pps),
      .rb_sel_i(rb_sel_i), .rb_data_o(rb_data_o),
      .leds_o(leds_o)
   );

   vita_timekeeper u_time (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_i(set_bus), .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_pps_o(vita_pps)
   );

   //////////////////////////////
   // Receive channels
   // All channels see the same ADC stream
   for (genvar g = 0; g < NUM_CHAN; g++) begin : g_rx
      rx_channel #(.CHAN_INDEX(g)) u_rx (
         .dsp_clk(dsp_clk), .por_rst(por_rst),
         .set_i(set_bus),
         .adc_i(adc_i), .adc_stb_i(adc_stb_i),
         .sample_o(rx_sample[g]), .sample_stb_o(rx_stb[g]),
         .run_o(rx_run[g])
      );
   end

   stream_merge #(.NUM_CHAN(NUM_CHAN)) u_merge (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .in_sample_i(rx_sample), .in_stb_i(rx_stb),
      .out_sample_o(out_sample_o), .out_chan_o(out_chan_o),
      .out_stb_o(out_stb_o), .overrun_o(overrun)
   );

endmodule

//--- rtl/radio_pkg.sv
/*
 * Radio core shared definitions: settings bus layout, register map,
 * readback selectors and sample types
 */
package radio_pkg;

   // Settings bus
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   typedef struct packed {
      logic                  stb;
      logic [SET_ADDR_W-1:0] addr;
      logic [SET_DATA_W-1:0] data;
   } set_bus_t;

   //////////////////////////////
   // Setting register map
   localparam logic [SET_ADDR_W-1:0] SR_LED_SW    = 8'd0;
   localparam logic [SET_ADDR_W-1:0] SR_LED_SRC   = 8'd1;
   localparam logic [SET_ADDR_W-1:0] SR_TIME_HI   = 8'd10;
   localparam logic [SET_ADDR_W-1:0] SR_TIME_LO   = 8'd11;
   localparam logic [SET_ADDR_W-1:0] SR_RX_BASE   = 8'd32;
   localparam logic [SET_ADDR_W-1:0] SR_RX_STRIDE = 8'd16;

   // Offsets inside one receive channel's window
   typedef enum logic [3:0] {
      RX_REG_RUN  = 4'd0,
      RX_REG_RATE = 4'd1
   } rx_reg_e;

   //////////////////////////////
   // Readback
   typedef enum logic [2:0] {
      RB_COMPAT = 3'd0, RB_TIME_HI = 3'd1, RB_TIME_LO = 3'd2,
      RB_PPS_HI = 3'd3, RB_PPS_LO = 3'd4, RB_STATUS = 3'd5
   } rb_sel_e;

   // Major in the upper half, minor in the lower
   localparam logic [31:0] COMPAT_NUM = {16'd3, 16'd1};

   // LEDs 1:0 follow the channel run bits out of reset
   localparam logic [7:0] LED_SRC_RESET = 8'h03;

   //////////////////////////////
   // Samples and time
   typedef struct packed {
      logic signed [15:0] i;
      logic signed [15:0] q;
   } iq_in_t;

   typedef struct packed {
      logic signed [23:0] i;
      logic signed [23:0] q;
   } iq_acc_t;

   typedef logic [63:0] vita_time_t;

endpackage

//--- rtl/rx_channel.sv
`timescale 1ns/1ns
/*
 * One receive channel: run and rate registers plus an
 * accumulate-and-dump decimator on the ADC I/Q stream
 */
module rx_channel #(
   parameter int CHAN_INDEX = 0
) (
   input  logic                dsp_clk,
   input  logic                por_rst,
   input  radio_pkg::set_bus_t set_i,
   input  radio_pkg::iq_in_t   adc_i,
   input  logic                adc_stb_i,
   output radio_pkg::iq_acc_t  sample_o,
   output logic                sample_stb_o,
   output logic                run_o
);

   localparam int BASE      = radio_pkg::SR_RX_BASE + CHAN_INDEX * radio_pkg::SR_RX_STRIDE;
   localparam int RUN_ADDR  = BASE + int'(radio_pkg::RX_REG_RUN);
   localparam int RATE_ADDR = BASE + int'(radio_pkg::RX_REG_RATE);

   logic               run_q;
   logic [7:0]         rate_q;
   logic [7:0]         cnt_q;
   logic [7:0]         last_cnt;
   logic               run_wr;
   logic               rate_wr;
   logic               run_keep;
   logic               dump;
   logic [23:0]        ext_i;
   logic [23:0]        ext_q;
   radio_pkg::iq_acc_t acc_q;
   radio_pkg::iq_acc_t sum;

   assign run_wr  = set_i.stb && (set_i.addr == RUN_ADDR[radio_pkg::SET_ADDR_W-1:0]);
   assign rate_wr = set_i.stb && (set_i.addr == RATE_ADDR[radio_pkg::SET_ADDR_W-1:0]);

   // Only accept input while run is set and not being cleared now
   assign run_keep = run_q && !(run_wr && !set_i.data[0]);

   // Rate 0 behaves as rate 1
   assign last_cnt = (rate_q == 8'd0) ? 8'd0 : rate_q - 8'd1;
   assign dump     = cnt_q >= last_cnt;

   assign ext_i = {{8{adc_i.i[15]}}, adc_i.i};
   assign ext_q = {{8{adc_i.q[15]}}, adc_i.q};

   // First input of a group starts the sum afresh
   assign sum.i = (cnt_q == 8'd0) ? ext_i : acc_q.i + ext_i;
   assign sum.q = (cnt_q == 8'd0) ? ext_q : acc_q.q + ext_q;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         run_q        <= 1'b0;
         rate_q       <= 8'd1;
         cnt_q        <= 8'd0;
         sample_stb_o <= 1'b0;
      end else begin
         sample_stb_o <= 1'b0;
         if (run_wr) run_q <= set_i.data[0];
         if (rate_wr) rate_q <= set_i.data[7:0];
         if (!run_keep) begin
            cnt_q <= 8'd0;
         end else if (adc_stb_i) begin
            cnt_q        <= dump ? 8'd0 : cnt_q + 8'd1;
            sample_stb_o <= dump;
         end
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (run_keep && adc_stb_i) begin
         if (dump) sample_o <= sum;
         else acc_q <= sum;
      end
   end

   assign run_o = run_q;

   a_stb_needs_run: assert property (@(posedge dsp_clk) disable iff (por_rst)
      sample_stb_o |-> run_q)
      else $error("rx sample strobe while channel stopped");

endmodule

//--- rtl/settings_hub.sv
`timescale 1ns/1ns
/*
 * Settings hub: registers the host settings bus, keeps the LED
 * registers and serves registered readback words
 */
module settings_hub #(
   parameter int NUM_CHAN = 2
) (
   input  logic                  dsp_clk,
   input  logic                  por_rst,
   input  radio_pkg::set_bus_t   set_i,
   output radio_pkg::set_bus_t   set_o,
   input  logic [NUM_CHAN-1:0]   run_i,
   input  logic [NUM_CHAN-1:0]   overrun_i,
   input  radio_pkg::vita_time_t vita_time_i,
   input  radio_pkg::vita_time_t vita_pps_i,
   input  radio_pkg::rb_sel_e    rb_sel_i,
   output logic [31:0]           rb_data_o,
   output logic [7:0]            leds_o
);

   logic                              stb_q;
   logic [radio_pkg::SET_ADDR_W-1:0]  addr_q;
   logic [radio_pkg::SET_DATA_W-1:0]  data_q;
   logic [7:0]                        led_sw_q;
   logic [7:0]                        led_src_q;
   logic [7:0]                        led_hw;
   logic [31:0]                       status_word;

   //////////////////////////////
   // Host bus register
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         stb_q <= 1'b0;
      end else begin
         stb_q <= set_i.stb;
      end
   end

   always_ff @(posedge dsp_clk) begin
      addr_q <= set_i.addr;
      data_q <= set_i.data;
   end

   assign set_o = '{stb: stb_q, addr: addr_q, data: data_q};

   //////////////////////////////
   // LED registers
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         led_sw_q  <= 8'h00;
         led_src_q <= radio_pkg::LED_SRC_RESET;
      end else if (stb_q) begin
         if (addr_q == radio_pkg::SR_LED_SW) led_sw_q <= data_q[7:0];
         if (addr_q == radio_pkg::SR_LED_SRC) led_src_q <= data_q[7:0];
      end
   end

   // Hardware word is just the run bits
   always_comb begin
      led_hw = 8'h00;
      led_hw[NUM_CHAN-1:0] = run_i;
   end

   // Set source bit picks hardware, clear picks software
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

   //////////////////////////////
   // Readback mux
   always_comb begin
      status_word = 32'h0;
      status_word[8 +: NUM_CHAN] = overrun_i;
      status_word[NUM_CHAN-1:0]  = run_i;
   end

   always_ff @(posedge dsp_clk) begin
      case (rb_sel_i)
         radio_pkg::RB_COMPAT:  rb_data_o <= radio_pkg::COMPAT_NUM;
         radio_pkg::RB_TIME_HI: rb_data_o <= vita_time_i[63:32];
         radio_pkg::RB_TIME_LO: rb_data_o <= vita_time_i[31:0];
         radio_pkg::RB_PPS_HI:  rb_data_o <= vita_pps_i[63:32];
         radio_pkg::RB_PPS_LO:  rb_data_o <= vita_pps_i[31:0];
         radio_pkg::RB_STATUS:  rb_data_o <= status_word;
         default:               rb_data_o <= 32'hffff_ffff;
      endcase
   end

   // A single host strobe must reach the receivers as a single strobe
   a_set_single: assert property (@(posedge dsp_clk) disable iff (por_rst)
      (set_i.stb ##1 !set_i.stb) |=> !set_o.stb)
      else $error("settings strobe stretched past one cycle");

endmodule

//--- rtl/stream_merge.sv
`timescale 1ns/1ns
/*
 * Stream merger: one holding register per channel, sends the
 * lowest-index pending sample each cycle and flags overruns
 */
module stream_merge #(
   parameter int NUM_CHAN = 2
) (
   input  logic                                        dsp_clk,
   input  logic                                        por_rst,
   input  radio_pkg::iq_acc_t                          in_sample_i [NUM_CHAN],
   input  logic [NUM_CHAN-1:0]                         in_stb_i,
   output radio_pkg::iq_acc_t                          out_sample_o,
   output logic [((NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1)-1:0] out_chan_o,
   output logic                                        out_stb_o,
   output logic [NUM_CHAN-1:0]                         overrun_o
);

   localparam int CHAN_W = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;

   radio_pkg::iq_acc_t  hold_q [NUM_CHAN];
   logic [NUM_CHAN-1:0] valid_q;
   logic [NUM_CHAN-1:0] pend;
   logic [NUM_CHAN-1:0] send;
   logic                sel_found;
   logic [CHAN_W-1:0]   sel_idx;
   radio_pkg::iq_acc_t  sel_sample;

   // A fresh sample counts as pending in the cycle it arrives
   assign pend = valid_q | in_stb_i;

   // Lowest index wins
   always_comb begin
      sel_found = 1'b0;
      sel_idx   = '0;
      for (int c = NUM_CHAN - 1; c >= 0; c--) begin
         if (pend[c]) begin
            sel_found = 1'b1;
            sel_idx   = CHAN_W'(c);
         end
      end
      send = '0;
      send[sel_idx] = sel_found;
   end

   // Held entry is older than the one arriving
   assign sel_sample = valid_q[sel_idx] ? hold_q[sel_idx] : in_sample_i[sel_idx];

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         valid_q   <= '0;
         overrun_o <= '0;
         out_stb_o <= 1'b0;
      end else begin
         out_stb_o <= sel_found;
         for (int c = 0; c < NUM_CHAN; c++) begin
            valid_q[c] <= send[c] ? (valid_q[c] & in_stb_i[c]) : (valid_q[c] | in_stb_i[c]);
            if (valid_q[c] && in_stb_i[c] && !send[c]) overrun_o[c] <= 1'b1;
         end
      end
   end

   always_ff @(posedge dsp_clk) begin
      for (int c = 0; c < NUM_CHAN; c++) begin
         if (in_stb_i[c]) hold_q[c] <= in_sample_i[c];
      end
      if (sel_found) begin
         out_sample_o <= sel_sample;
         out_chan_o   <= sel_idx;
      end
   end

   a_sent_was_pending: assert property (@(posedge dsp_clk) disable iff (por_rst)
      out_stb_o |-> |($past(pend) & (NUM_CHAN'(1) << out_chan_o)))
      else $error("merger sent an entry that was not pending");

endmodule

//--- rtl/vita_timekeeper.sv
`timescale 1ns/1ns
/*
 * 64-bit timekeeper, loadable over the settings bus, with a
 * capture of the count at every PPS rising edge
 */
module vita_timekeeper (
   input  logic                  dsp_clk,
   input  logic                  por_rst,
   input  radio_pkg::set_bus_t   set_i,
   input  logic                  pps_i,
   output radio_pkg::vita_time_t vita_time_o,
   output radio_pkg::vita_time_t vita_pps_o
);

   logic [31:0] time_hi_q;
   logic        pps_meta_q;
   logic        pps_sync_q;
   logic        pps_prev_q;
   logic        pps_rise;
   logic        hi_wr;
   logic        lo_wr;

   assign hi_wr = set_i.stb && (set_i.addr == radio_pkg::SR_TIME_HI);
   assign lo_wr = set_i.stb && (set_i.addr == radio_pkg::SR_TIME_LO);

   //////////////////////////////
   // Time count
   // High word waits here until the low word arrives
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_hi_q   <= 32'h0;
         vita_time_o <= '0;
      end else begin
         if (hi_wr) time_hi_q <= set_i.data;
         if (lo_wr) begin
            vita_time_o <= {time_hi_q, set_i.data};
         end else begin
            vita_time_o <= vita_time_o + 64'd1;
         end
      end
   end

   //////////////////////////////
   // PPS capture
   // Two flops against metastability, third one for the edge
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_meta_q <= 1'b0;
         pps_sync_q <= 1'b0;
         pps_prev_q <= 1'b0;
      end else begin
         pps_meta_q <= pps_i;
         pps_sync_q <= pps_meta_q;
         pps_prev_q <= pps_sync_q;
      end
   end

   assign pps_rise = pps_sync_q & ~pps_prev_q;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_pps_o <= '0;
      end else if (pps_rise) begin
         vita_pps_o <= vita_time_o;
      end
   end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the radio core testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -f sources.f \
   --top-module radio_core_tb -o radio_core_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/radio_core_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
fi

if grep -F -q '*** TEST PASSED ***' "$LOG"; then
   exit 0
fi
exit 1

//--- sources.f
rtl/radio_pkg.sv
rtl/settings_hub.sv
rtl/vita_timekeeper.sv
rtl/rx_channel.sv
rtl/stream_merge.sv
rtl/radio_core.sv
dv/radio_core_tb.sv
